// ==== acc_management.f ====
design/mem_req_pkg.sv
design/acc_conf_pkg.sv
design/req_fifo.sv
design/req_arbiter_tree.sv
design/queue_reader.sv
design/queue_writer.sv
design/acc_core.sv
design/acc_management.sv
tb/acc_checker.sv
tb/tb_acc_management.sv

// ==== design/acc_conf_pkg.sv ====
package acc_conf_pkg;

  localparam int qtd_w = 32;
  localparam int conf_id_w = 32;
  localparam int lane_w = 32;

  localparam int num_in_q = 2;
  localparam int num_out_q = 2;
  localparam int num_wr_ports = num_out_q + 1; // Output queues plus the completion record
  localparam int status_q_id = 2;

  // Conf word is address, then line count, then queue id
  localparam int conf_addr_lsb = 0;
  localparam int conf_qtd_lsb = conf_addr_lsb + mem_req_pkg::addr_w;
  localparam int conf_id_lsb = conf_qtd_lsb + qtd_w;
  localparam int conf_used_w = conf_id_lsb + conf_id_w;

  localparam int info_cnt_w = 8;
  localparam int info_out_q_lsb = 0;
  localparam int info_in_q_lsb = 8;
  localparam int info_done_bit = 16;

endpackage

// ==== design/acc_core.sv ====
`timescale 1ns/1ps

module acc_core (
  input logic clk,
  input logic rst,
  input logic start,
  input logic [1:0] conf_valid,
  input logic [acc_conf_pkg::conf_used_w-1:0] conf,
  output logic rd_req_en [acc_conf_pkg::num_in_q],
  output mem_req_pkg::rd_req_t rd_req_data [acc_conf_pkg::num_in_q],
  input logic rd_available [acc_conf_pkg::num_in_q],
  input logic resp_rd_valid,
  input logic [mem_req_pkg::tag_w-1:0] resp_rd_mdata,
  input logic [mem_req_pkg::data_w-1:0] resp_rd_data,
  output logic wr_req_en [acc_conf_pkg::num_wr_ports],
  output mem_req_pkg::wr_req_t wr_req_data [acc_conf_pkg::num_wr_ports],
  input logic wr_available [acc_conf_pkg::num_wr_ports],
  input logic resp_wr_valid,
  output logic done
);

  import mem_req_pkg::*;
  import acc_conf_pkg::*;

  logic [addr_w-1:0] conf_addr;
  logic [qtd_w-1:0] conf_qtd;
  logic [conf_id_w-1:0] conf_id;
  logic [qtd_w-1:0] qtd_q;
  logic [qtd_w-1:0] pairs_left_q;
  logic [addr_w-1:0] status_addr_q;
  logic [qtd_w:0] wr_resp_cnt_q;
  logic running_q;
  logic issue_q;
  logic rec_pend_q;
  logic rec_sent_q;
  logic done_q;
  logic pair_go;
  logic finish;
  logic line_valid [num_in_q];
  logic [data_w-1:0] line_data [num_in_q];
  logic room [num_out_q];
  logic [data_w-1:0] lane_res [num_out_q];

  assign conf_addr = conf[conf_addr_lsb +: addr_w];
  assign conf_qtd = conf[conf_qtd_lsb +: qtd_w];
  assign conf_id = conf[conf_id_lsb +: conf_id_w];

  for (genvar k = 0; k < num_in_q; k++) begin : g_rd
    queue_reader #(.queue_id(k)) u_reader (
      .clk(clk),
      .rst(rst),
      .start(start),
      .conf_en(conf_valid[0] && (conf_id == conf_id_w'(k))),
      .base_addr(conf_addr),
      .qtd(qtd_q), // Both inputs run on the line count of queue 0
      .req_en(rd_req_en[k]),
      .req_data(rd_req_data[k]),
      .req_available(rd_available[k]),
      .resp_valid(resp_rd_valid),
      .resp_tag(resp_rd_mdata),
      .resp_data(resp_rd_data),
      .line_valid(line_valid[k]),
      .line_data(line_data[k]),
      .line_pop(pair_go)
    );
  end

  for (genvar k = 0; k < num_out_q; k++) begin : g_wr
    queue_writer #(.queue_id(k)) u_writer (
      .clk(clk),
      .rst(rst),
      .start(start),
      .conf_en(conf_valid[1] && (conf_id == conf_id_w'(k))),
      .base_addr(conf_addr),
      .line_en(issue_q),
      .line_data(lane_res[k]),
      .room(room[k]),
      .req_en(wr_req_en[k]),
      .req_data(wr_req_data[k]),
      .req_available(wr_available[k])
    );
  end

  // Pairs are taken every other cycle so a writer never gets a line it has no room for
  assign pair_go = running_q && !issue_q && (pairs_left_q != '0)
                   && line_valid[0] && line_valid[1] && room[0] && room[1];

  always_comb begin
    for (int i = 0; i < data_w / lane_w; i++) begin
      lane_res[0][i*lane_w +: lane_w] = line_data[0][i*lane_w +: lane_w]
                                        + line_data[1][i*lane_w +: lane_w];
      lane_res[1][i*lane_w +: lane_w] = line_data[0][i*lane_w +: lane_w]
                                        ^ line_data[1][i*lane_w +: lane_w];
    end
  end

  assign wr_req_en[num_out_q] = rec_pend_q && wr_available[num_out_q];
  assign wr_req_data[num_out_q] = '{data: {{(data_w - qtd_w){1'b1}}, qtd_q},
                                    addr: status_addr_q,
                                    tag: tag_w'(status_q_id)};

  // Only the record's own response can arrive once the record has been sent
  assign finish = running_q && rec_sent_q && resp_wr_valid;
  assign done = done_q || finish;

  always_ff @(posedge clk) begin
    if (conf_valid[0] && (conf_id == '0)) qtd_q <= conf_qtd;
    if (conf_valid[1] && (conf_id == conf_id_w'(status_q_id))) status_addr_q <= conf_addr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      running_q <= 1'b0;
      issue_q <= 1'b0;
      pairs_left_q <= '0;
      wr_resp_cnt_q <= '0;
      rec_pend_q <= 1'b0;
      rec_sent_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      issue_q <= pair_go;
      if (start) begin
        running_q <= 1'b1;
        pairs_left_q <= qtd_q;
        wr_resp_cnt_q <= '0;
        rec_sent_q <= 1'b0;
        done_q <= 1'b0;
      end else begin
        if (pair_go) pairs_left_q <= pairs_left_q - 1'b1;
        if (resp_wr_valid && !rec_sent_q) wr_resp_cnt_q <= wr_resp_cnt_q + 1'b1;
        if (running_q && !rec_pend_q && !rec_sent_q && (wr_resp_cnt_q == {qtd_q, 1'b0}))
          rec_pend_q <= 1'b1;
        if (wr_req_en[num_out_q]) begin
          rec_pend_q <= 1'b0;
          rec_sent_q <= 1'b1;
        end
        if (finish) begin
          done_q <= 1'b1;
          running_q <= 1'b0;
        end
      end
    end
  end

  a_conf_idle: assert property (@(posedge clk) disable iff (rst)
    (conf_valid != 2'b00) |-> !running_q);

endmodule

// ==== design/acc_management.sv ====
`timescale 1ns/1ps

module acc_management (
  input logic clk,
  input logic rst,
  input logic [63:0] rst_accs,
  input logic [63:0] start_accs,
  input logic [1:0] conf_valid,
  input logic [127:0] conf,
  output logic req_rd_en,
  output logic [mem_req_pkg::addr_w-1:0] req_rd_addr,
  output logic [mem_req_pkg::tag_w-1:0] req_rd_mdata,
  input logic req_rd_available,
  input logic resp_rd_valid,
  input logic [mem_req_pkg::data_w-1:0] resp_rd_data,
  input logic [mem_req_pkg::tag_w-1:0] resp_rd_mdata,
  input logic req_wr_available,
  output logic req_wr_en,
  output logic [mem_req_pkg::addr_w-1:0] req_wr_addr,
  output logic [mem_req_pkg::tag_w-1:0] req_wr_mdata,
  output logic [mem_req_pkg::data_w-1:0] req_wr_data,
  input logic resp_wr_valid,
  input logic [mem_req_pkg::tag_w-1:0] resp_wr_mdata,
  output logic [511:0] info
);

  import mem_req_pkg::*;
  import acc_conf_pkg::*;

  logic acc_rst;
  logic core_done;
  logic rd_en_in [num_in_q];
  rd_req_t rd_data_in [num_in_q];
  logic rd_avail_in [num_in_q];
  logic rd_en_out;
  rd_req_t rd_data_out;
  logic wr_en_in [num_wr_ports];
  wr_req_t wr_data_in [num_wr_ports];
  logic wr_avail_in [num_wr_ports];
  logic wr_en_out;
  wr_req_t wr_data_out;
  logic [511:0] info_base;

  // The trees serve only this accelerator, so its own reset flushes them too
  assign acc_rst = rst | rst_accs[0];

  acc_core u_acc_core (
    .clk(clk),
    .rst(acc_rst),
    .start(start_accs[0]),
    .conf_valid(conf_valid),
    .conf(conf[conf_used_w-1:0]),
    .rd_req_en(rd_en_in),
    .rd_req_data(rd_data_in),
    .rd_available(rd_avail_in),
    .resp_rd_valid(resp_rd_valid),
    .resp_rd_mdata(resp_rd_mdata),
    .resp_rd_data(resp_rd_data),
    .wr_req_en(wr_en_in),
    .wr_req_data(wr_data_in),
    .wr_available(wr_avail_in),
    .resp_wr_valid(resp_wr_valid),
    .done(core_done)
  );

  req_arbiter_tree #(.payload_t(rd_req_t), .num_in(num_in_q), .depth_bits(4)) u_rd_tree (
    .clk(clk),
    .rst(acc_rst),
    .en_in(rd_en_in),
    .data_in(rd_data_in),
    .available_in(rd_avail_in),
    .available_out(req_rd_available),
    .en_out(rd_en_out),
    .data_out(rd_data_out)
  );

  req_arbiter_tree #(.payload_t(wr_req_t), .num_in(num_wr_ports), .depth_bits(4)) u_wr_tree (
    .clk(clk),
    .rst(acc_rst),
    .en_in(wr_en_in),
    .data_in(wr_data_in),
    .available_in(wr_avail_in),
    .available_out(req_wr_available),
    .en_out(wr_en_out),
    .data_out(wr_data_out)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      req_rd_en <= 1'b0;
      req_wr_en <= 1'b0;
    end else begin
      req_rd_en <= rd_en_out;
      req_wr_en <= wr_en_out;
    end
  end

  always_ff @(posedge clk) begin
    req_rd_addr <= rd_data_out.addr;
    req_rd_mdata <= rd_data_out.tag;
    req_wr_data <= wr_data_out.data;
    req_wr_addr <= wr_data_out.addr;
    req_wr_mdata <= wr_data_out.tag;
  end

  always_comb begin
    info_base = '0;
    info_base[info_in_q_lsb +: info_cnt_w] = info_cnt_w'(num_in_q);
    info_base[info_out_q_lsb +: info_cnt_w] = info_cnt_w'(num_out_q);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      info <= info_base;
    end else begin
      info <= info_base;
      info[info_done_bit] <= core_done;
    end
  end

  // Write responses echo one of the three write ports' tags
  a_wr_resp_tag: assert property (@(posedge clk) disable iff (rst)
    resp_wr_valid |-> (resp_wr_mdata <= tag_w'(status_q_id)));

endmodule

// ==== design/mem_req_pkg.sv ====
package mem_req_pkg;

  localparam int addr_w = 48;
  localparam int tag_w = 16;
  localparam int data_w = 512;
  localparam int line_bytes = 64; // One cache line per address step

  // Tag sits in the low bits, the same order as the memory port fields
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [tag_w-1:0] tag;
  } rd_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [addr_w-1:0] addr;
    logic [tag_w-1:0] tag;
  } wr_req_t;

endpackage

// ==== design/queue_reader.sv ====
`timescale 1ns/1ps

module queue_reader #(
  parameter int queue_id = 0
) (
  input logic clk,
  input logic rst,
  input logic start,
  input logic conf_en,
  input logic [mem_req_pkg::addr_w-1:0] base_addr,
  input logic [acc_conf_pkg::qtd_w-1:0] qtd,
  output logic req_en,
  output mem_req_pkg::rd_req_t req_data,
  input logic req_available,
  input logic resp_valid,
  input logic [mem_req_pkg::tag_w-1:0] resp_tag,
  input logic [mem_req_pkg::data_w-1:0] resp_data,
  output logic line_valid,
  output logic [mem_req_pkg::data_w-1:0] line_data,
  input logic line_pop
);

  import mem_req_pkg::*;
  import acc_conf_pkg::*;

  localparam int buf_bits = 3;

  logic [addr_w-1:0] base_q;
  logic [addr_w-1:0] addr_q;
  logic [qtd_w-1:0] left_q;
  logic [buf_bits:0] in_use_q; // Lines in the buffer plus reads still outstanding
  logic buf_empty;
  logic resp_hit;

  always_ff @(posedge clk) begin
    if (conf_en) base_q <= base_addr;
    if (start) begin
      addr_q <= base_q;
    end else if (req_en) begin
      addr_q <= addr_q + addr_w'(line_bytes);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      left_q <= '0;
      in_use_q <= '0;
    end else begin
      if (start) begin
        left_q <= qtd;
      end else if (req_en) begin
        left_q <= left_q - 1'b1;
      end
      in_use_q <= in_use_q + (buf_bits+1)'(req_en) - (buf_bits+1)'(line_pop);
    end
  end

  assign req_en = (left_q != '0) && req_available && (in_use_q < (buf_bits+1)'(1 << buf_bits));
  assign req_data = '{addr: addr_q, tag: tag_w'(queue_id)};

  assign resp_hit = resp_valid && (resp_tag == tag_w'(queue_id));

  req_fifo #(.payload_t(logic [data_w-1:0]), .depth_bits(buf_bits)) u_line_fifo (
    .clk(clk),
    .rst(rst),
    .wr_en(resp_hit),
    .wr_data(resp_data),
    .rd_en(line_pop),
    .rd_data(line_data),
    .empty(buf_empty),
    .almost_full()
  );

  assign line_valid = !buf_empty;

endmodule

// ==== design/queue_writer.sv ====
`timescale 1ns/1ps

module queue_writer #(
  parameter int queue_id = 0
) (
  input logic clk,
  input logic rst,
  input logic start,
  input logic conf_en,
  input logic [mem_req_pkg::addr_w-1:0] base_addr,
  input logic line_en,
  input logic [mem_req_pkg::data_w-1:0] line_data,
  output logic room,
  output logic req_en,
  output mem_req_pkg::wr_req_t req_data,
  input logic req_available
);

  import mem_req_pkg::*;

  logic [addr_w-1:0] base_q;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] pend_data;
  logic pending_q;

  always_ff @(posedge clk) begin
    if (conf_en) base_q <= base_addr;
    if (start) begin
      addr_q <= base_q;
    end else if (req_en) begin
      addr_q <= addr_q + addr_w'(line_bytes);
    end
    if (line_en) pend_data <= line_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (line_en) begin
      pending_q <= 1'b1;
    end else if (req_en) begin
      pending_q <= 1'b0;
    end
  end

  assign req_en = pending_q && req_available;
  assign room = !pending_q || req_en; // A leaving line frees the slot for the next one
  assign req_data = '{data: pend_data, addr: addr_q, tag: tag_w'(queue_id)};

endmodule

// ==== design/req_arbiter_tree.sv ====
`timescale 1ns/1ps

module req_arbiter_tree #(
  parameter type payload_t = logic [7:0],
  parameter int num_in = 2,
  parameter int depth_bits = 4
) (
  input logic clk,
  input logic rst,
  input logic en_in [num_in],
  input payload_t data_in [num_in],
  output logic available_in [num_in],
  input logic available_out,
  output logic en_out,
  output payload_t data_out
);

  localparam int sel_w = (num_in > 1) ? $clog2(num_in) : 1;

  payload_t in_rd_data [num_in];
  logic in_empty [num_in];
  logic in_af [num_in];
  logic in_rd_en [num_in];
  logic [sel_w-1:0] rr_ptr;
  logic [sel_w-1:0] pick;
  logic pick_valid;
  logic in_pop;
  logic mv_valid_q;
  logic [sel_w-1:0] mv_sel_q;
  logic out_empty;
  logic out_af;
  logic out_pop;
  logic out_valid_q;

  for (genvar k = 0; k < num_in; k++) begin : g_in
    req_fifo #(.payload_t(payload_t), .depth_bits(depth_bits)) u_in_fifo (
      .clk(clk),
      .rst(rst),
      .wr_en(en_in[k]),
      .wr_data(data_in[k]),
      .rd_en(in_rd_en[k]),
      .rd_data(in_rd_data[k]),
      .empty(in_empty[k]),
      .almost_full(in_af[k])
    );
    assign available_in[k] = !in_af[k];
    assign in_rd_en[k] = in_pop && (pick == sel_w'(k));

    a_en_when_avail: assert property (@(posedge clk) disable iff (rst)
      en_in[k] |-> available_in[k]);
  end

  // First non-empty input at or after the round-robin pointer
  always_comb begin
    int idx;
    pick_valid = 1'b0;
    pick = '0;
    for (int i = 0; i < num_in; i++) begin
      idx = (int'(rr_ptr) + i) % num_in;
      if (!pick_valid && !in_empty[idx]) begin
        pick_valid = 1'b1;
        pick = sel_w'(idx);
      end
    end
  end

  assign in_pop = pick_valid && !out_af;

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
      mv_valid_q <= 1'b0;
    end else begin
      mv_valid_q <= in_pop;
      if (in_pop) rr_ptr <= (pick == sel_w'(num_in - 1)) ? '0 : pick + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_pop) mv_sel_q <= pick;
  end

  req_fifo #(.payload_t(payload_t), .depth_bits(depth_bits)) u_out_fifo (
    .clk(clk),
    .rst(rst),
    .wr_en(mv_valid_q),
    .wr_data(in_rd_data[mv_sel_q]),
    .rd_en(out_pop),
    .rd_data(data_out),
    .empty(out_empty),
    .almost_full(out_af)
  );

  // The popped head waits in the FIFO read register until the port is available
  assign en_out = out_valid_q && available_out;
  assign out_pop = !out_empty && (!out_valid_q || en_out);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (out_pop) begin
      out_valid_q <= 1'b1;
    end else if (en_out) begin
      out_valid_q <= 1'b0;
    end
  end

endmodule

// ==== design/req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int depth_bits = 4
) (
  input logic clk,
  input logic rst,
  input logic wr_en,
  input payload_t wr_data,
  input logic rd_en,
  output payload_t rd_data,
  output logic empty,
  output logic almost_full
);

  localparam int depth = 1 << depth_bits;

  payload_t mem [depth];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0] count;
  logic full;

  assign empty = (count == '0);
  assign full = (count == (depth_bits+1)'(depth));
  // Two slots stay free for writes already on their way
  assign almost_full = (count >= (depth_bits+1)'(depth - 2));

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
    if (rd_en) rd_data <= mem[rd_ptr]; // Read data shows up one cycle after rd_en
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (depth_bits+1)'(wr_en) - (depth_bits+1)'(rd_en);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty);

endmodule

// ==== tb/acc_checker.sv ====
`timescale 1ns/1ps

module acc_checker (
  input logic clk,
  input logic rst,
  input logic req_rd_en,
  input logic req_rd_available,
  input logic req_wr_en,
  input logic req_wr_available,
  input logic [mem_req_pkg::addr_w-1:0] req_wr_addr,
  input logic [mem_req_pkg::tag_w-1:0] req_wr_mdata,
  input logic [mem_req_pkg::data_w-1:0] req_wr_data
);

  import mem_req_pkg::*;

  localparam int lane_bits = 32;
  localparam int rec_tag = 2;

  logic [addr_w-1:0] exp_addr [$];
  logic [data_w-1:0] exp_data [$];
  logic [tag_w-1:0] exp_tag [$];
  bit exp_seen [$];
  int errors = 0;
  int seen_lines = 0;
  int seen_recs = 0;
  logic rd_avail_last = 1'b1; // Level the DUT sampled at the edge before this cycle
  logic wr_avail_last = 1'b1;

  // Output queue 0 gets the lane-wise sum of both input lines, output queue 1 the XOR
  function automatic logic [data_w-1:0] lane_ref(input logic [data_w-1:0] a,
                                                 input logic [data_w-1:0] b,
                                                 input bit use_xor);
    logic [data_w-1:0] r;
    for (int i = 0; i < data_w / lane_bits; i++) begin
      if (use_xor)
        r[i*lane_bits +: lane_bits] = a[i*lane_bits +: lane_bits] ^ b[i*lane_bits +: lane_bits];
      else
        r[i*lane_bits +: lane_bits] = a[i*lane_bits +: lane_bits] + b[i*lane_bits +: lane_bits];
    end
    return r;
  endfunction

  task automatic clear_expect();
    exp_addr.delete();
    exp_data.delete();
    exp_tag.delete();
    exp_seen.delete();
    seen_lines = 0;
    seen_recs = 0;
  endtask

  task automatic add_expect(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                            input int tag);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_tag.push_back(tag_w'(tag));
    exp_seen.push_back(1'b0);
  endtask

  task automatic expect_pair(input logic [addr_w-1:0] out0, input logic [addr_w-1:0] out1,
                             input logic [data_w-1:0] in0, input logic [data_w-1:0] in1);
    add_expect(out0, lane_ref(in0, in1, 1'b0), 0);
    add_expect(out1, lane_ref(in0, in1, 1'b1), 1);
  endtask

  // Completion record holds the line count with all bits above it set
  task automatic expect_record(input logic [addr_w-1:0] addr, input logic [31:0] lines);
    add_expect(addr, {{(data_w - 32){1'b1}}, lines}, rec_tag);
  endtask

  always @(negedge clk) begin
    int idx;
    int lane;
    if (!rst) begin
      if (req_rd_en && !rd_avail_last) begin
        errors++;
        $display("Error at %0t: read request after req_rd_available was low", $time);
      end
      if (req_wr_en && !wr_avail_last) begin
        errors++;
        $display("Error at %0t: write request after req_wr_available was low", $time);
      end
      if (req_wr_en) begin
        idx = -1;
        foreach (exp_addr[i]) begin
          if (exp_addr[i] == req_wr_addr) idx = i;
        end
        if (idx < 0) begin
          errors++;
          $display("Error at %0t: write to unexpected address %h", $time, req_wr_addr);
        end else if (exp_seen[idx]) begin
          errors++;
          $display("Error at %0t: second write to address %h", $time, req_wr_addr);
        end else begin
          exp_seen[idx] = 1'b1;
          if (req_wr_mdata !== exp_tag[idx]) begin
            errors++;
            $display("Error at %0t: write to %h has mdata %0d, expected %0d", $time,
                     req_wr_addr, req_wr_mdata, exp_tag[idx]);
          end else if (req_wr_data !== exp_data[idx]) begin
            lane = 0;
            for (int i = data_w / lane_bits - 1; i >= 0; i--) begin
              if (req_wr_data[i*lane_bits +: lane_bits] !== exp_data[idx][i*lane_bits +: lane_bits])
                lane = i;
            end
            errors++;
            $display("Error at %0t: write to %h lane %0d is %h, expected %h", $time,
                     req_wr_addr, lane, req_wr_data[lane*lane_bits +: lane_bits],
                     exp_data[idx][lane*lane_bits +: lane_bits]);
          end else if (exp_tag[idx] == tag_w'(rec_tag)) begin
            seen_recs++;
          end else begin
            seen_lines++;
          end
        end
      end
    end
    rd_avail_last = req_rd_available;
    wr_avail_last = req_wr_available;
  end

endmodule

// ==== tb/tb_acc_management.sv ====
`timescale 1ns/1ps

module tb_acc_management;

  import mem_req_pkg::*;

  localparam int seed = 57914;
  localparam int mem_lines = 512;
  localparam int done_bit = 16;
  localparam int conf_qtd_at = 48;
  localparam int conf_id_at = 80;
  localparam int total_lines = 8 + 8 + 8 + 5; // Lines configured over all runs
  localparam int timeout_cycles = 400 * total_lines + 2000;

  logic clk;
  logic rst;
  logic [63:0] rst_accs;
  logic [63:0] start_accs;
  logic [1:0] conf_valid;
  logic [127:0] conf;
  logic req_rd_en;
  logic [addr_w-1:0] req_rd_addr;
  logic [tag_w-1:0] req_rd_mdata;
  logic req_rd_available;
  logic resp_rd_valid;
  logic [data_w-1:0] resp_rd_data;
  logic [tag_w-1:0] resp_rd_mdata;
  logic req_wr_available;
  logic req_wr_en;
  logic [addr_w-1:0] req_wr_addr;
  logic [tag_w-1:0] req_wr_mdata;
  logic [data_w-1:0] req_wr_data;
  logic resp_wr_valid;
  logic [tag_w-1:0] resp_wr_mdata;
  logic [511:0] info;

  logic [data_w-1:0] mem [mem_lines];
  int rd_line [$];
  logic [tag_w-1:0] rd_tag [$];
  int rd_due [$];
  logic [tag_w-1:0] wr_tag [$];
  int wr_due [$];
  int now = 0;
  bit toggle_avail = 1'b0;
  int tb_errors = 0;
  int passed = 0;
  int failed = 0;

  acc_management u_dut (
    .clk(clk),
    .rst(rst),
    .rst_accs(rst_accs),
    .start_accs(start_accs),
    .conf_valid(conf_valid),
    .conf(conf),
    .req_rd_en(req_rd_en),
    .req_rd_addr(req_rd_addr),
    .req_rd_mdata(req_rd_mdata),
    .req_rd_available(req_rd_available),
    .resp_rd_valid(resp_rd_valid),
    .resp_rd_data(resp_rd_data),
    .resp_rd_mdata(resp_rd_mdata),
    .req_wr_available(req_wr_available),
    .req_wr_en(req_wr_en),
    .req_wr_addr(req_wr_addr),
    .req_wr_mdata(req_wr_mdata),
    .req_wr_data(req_wr_data),
    .resp_wr_valid(resp_wr_valid),
    .resp_wr_mdata(resp_wr_mdata),
    .info(info)
  );

  acc_checker u_chk (
    .clk(clk),
    .rst(rst),
    .req_rd_en(req_rd_en),
    .req_rd_available(req_rd_available),
    .req_wr_en(req_wr_en),
    .req_wr_available(req_wr_available),
    .req_wr_addr(req_wr_addr),
    .req_wr_mdata(req_wr_mdata),
    .req_wr_data(req_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int line_of(input logic [addr_w-1:0] addr);
    if (addr >= addr_w'(mem_lines * line_bytes)) begin
      tb_errors++;
      $display("Error at %0t: access to %h is outside the memory model", $time, addr);
      return 0;
    end
    return int'(addr / line_bytes);
  endfunction

  function automatic int err_total();
    return tb_errors + u_chk.errors;
  endfunction

  // Requests are taken from the registered ports where they are stable
  always @(negedge clk) begin
    if (!rst && req_rd_en) begin
      rd_line.push_back(line_of(req_rd_addr));
      rd_tag.push_back(req_rd_mdata);
      rd_due.push_back(now + 1 + int'($urandom % 8));
    end
    if (!rst && req_wr_en) begin
      mem[line_of(req_wr_addr)] = req_wr_data;
      wr_tag.push_back(req_wr_mdata);
      wr_due.push_back(now + 1 + int'($urandom % 8));
    end
  end

  // Memory answers in request order, which keeps the order per tag as well
  initial begin : mem_model
    bit toggle_now;
    resp_rd_valid = 1'b0;
    resp_rd_data = '0;
    resp_rd_mdata = '0;
    resp_wr_valid = 1'b0;
    resp_wr_mdata = '0;
    req_rd_available = 1'b1;
    req_wr_available = 1'b1;
    forever begin
      @(posedge clk);
      now++;
      toggle_now = toggle_avail;
      #1;
      resp_rd_valid = 1'b0;
      resp_wr_valid = 1'b0;
      if (rd_due.size() > 0 && rd_due[0] <= now) begin
        resp_rd_valid = 1'b1;
        resp_rd_mdata = rd_tag.pop_front();
        resp_rd_data = mem[rd_line.pop_front()];
        void'(rd_due.pop_front());
      end
      if (wr_due.size() > 0 && wr_due[0] <= now) begin
        resp_wr_valid = 1'b1;
        resp_wr_mdata = wr_tag.pop_front();
        void'(wr_due.pop_front());
      end
      req_rd_available = toggle_now ? (($urandom % 2) == 1) : 1'b1;
      req_wr_available = toggle_now ? (($urandom % 2) == 1) : 1'b1;
    end
  end

  task automatic send_conf(input logic [1:0] sel, input logic [addr_w-1:0] addr,
                           input int qtd, input int id);
    conf = '0;
    conf[addr_w-1:0] = addr;
    conf[conf_qtd_at +: 32] = 32'(qtd);
    conf[conf_id_at +: 32] = 32'(id);
    conf_valid = sel;
    @(posedge clk);
    #1;
    conf_valid = 2'b00;
  endtask

  task automatic setup_run(input logic [addr_w-1:0] in0, input logic [addr_w-1:0] in1,
                           input logic [addr_w-1:0] out0, input logic [addr_w-1:0] out1,
                           input logic [addr_w-1:0] status, input int qtd);
    send_conf(2'b01, in0, qtd, 0);
    send_conf(2'b01, in1, qtd, 1);
    send_conf(2'b10, out0, 0, 0);
    send_conf(2'b10, out1, 0, 1);
    send_conf(2'b10, status, 0, 2);
    u_chk.clear_expect();
    for (int i = 0; i < qtd; i++) begin
      u_chk.expect_pair(out0 + addr_w'(line_bytes * i), out1 + addr_w'(line_bytes * i),
                        mem[line_of(in0) + i], mem[line_of(in1) + i]);
    end
    u_chk.expect_record(status, 32'(qtd));
    start_accs[0] = 1'b1;
    @(posedge clk);
    #1;
    start_accs[0] = 1'b0;
    @(posedge clk); // Done bit of the previous run clears one cycle after start
    #1;
  endtask

  task automatic wait_done(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = info[done_bit];
      n++;
    end
    @(posedge clk);
    #1;
    if (!seen) $display("Done bit did not rise within %0d cycles", limit);
  endtask

  // Stale responses would land in the reader buffers, so the memory drains under reset
  task automatic reset_acc_and_drain();
    rst_accs[0] = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    while (rd_due.size() != 0 || wr_due.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
    rst_accs[0] = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input int num, input string name, input bit ok);
    if (ok) begin
      passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      failed++;
      $display("test %0d %s: failed", num, name);
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    bit done_ok;
    int e0;
    void'($urandom(seed));
    rst = 1'b1;
    rst_accs = '0;
    start_accs = '0;
    conf_valid = 2'b00;
    conf = '0;
    for (int i = 0; i < mem_lines; i++) begin
      for (int l = 0; l < data_w / 32; l++) mem[i][l*32 +: 32] = $urandom;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    e0 = err_total();
    if (info[15:0] !== 16'h0202 || info[done_bit] !== 1'b0) begin
      tb_errors++;
      $display("Error at %0t: info after reset is %h, expected 0202 with done low", $time,
               info[16:0]);
    end
    repeat (20) begin
      @(negedge clk);
      if (req_rd_en !== 1'b0 || req_wr_en !== 1'b0) begin
        tb_errors++;
        $display("Error at %0t: memory request before start", $time);
      end
    end
    @(posedge clk);
    #1;
    report_test(1, "reset state", err_total() == e0);

    e0 = err_total();
    setup_run(48'h0000, 48'h1000, 48'h2000, 48'h3000, 48'h4000, 8);
    wait_done(400 * 8, done_ok);
    report_test(2, "sum and xor writes", err_total() == e0 && u_chk.seen_lines == 16);
    report_test(3, "completion record and done", done_ok && u_chk.seen_recs == 1);

    e0 = err_total();
    toggle_avail = 1'b1;
    setup_run(48'h0000, 48'h1000, 48'h5000, 48'h6000, 48'h7000, 8);
    wait_done(400 * 8, done_ok);
    toggle_avail = 1'b0;
    report_test(4, "random back-pressure", done_ok && err_total() == e0
                && u_chk.seen_lines == 16 && u_chk.seen_recs == 1);

    e0 = err_total();
    setup_run(48'h0000, 48'h1000, 48'h2000, 48'h3000, 48'h4000, 8);
    repeat (30) @(posedge clk);
    #1;
    reset_acc_and_drain();
    setup_run(48'h0800, 48'h1800, 48'h2800, 48'h3800, 48'h4800, 5);
    wait_done(400 * 5, done_ok);
    report_test(5, "accelerator reset and rerun", done_ok && err_total() == e0
                && u_chk.seen_lines == 10 && u_chk.seen_recs == 1);

    $display("tests passed %0d, failed %0d, check errors %0d", passed, failed, err_total());
    if (failed == 0 && err_total() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
